// File: design/mips_decode_pkg.sv
`default_nettype none

package mips_decode_pkg;

	typedef logic [4:0] reg_idx_t;
	typedef logic [15:0] imm_t;

	localparam reg_idx_t REG_RA = 5'd31; // link register for jal

	// major opcodes, insn[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'd0, OP_REGIMM = 6'd1, OP_J = 6'd2, OP_JAL = 6'd3,
		OP_BEQ = 6'd4, OP_BNE = 6'd5, OP_BLEZ = 6'd6, OP_BGTZ = 6'd7,
		OP_ADDIU = 6'd9, OP_SLTI = 6'd10, OP_SLTIU = 6'd11, OP_ANDI = 6'd12,
		OP_ORI = 6'd13, OP_XORI = 6'd14, OP_LUI = 6'd15,
		OP_LB = 6'd32, OP_LH = 6'd33, OP_LW = 6'd35, OP_LBU = 6'd36, OP_LHU = 6'd37,
		OP_SB = 6'd40, OP_SH = 6'd41, OP_SW = 6'd43
	} major_op_e;

	// SPECIAL function codes, insn[5:0]
	typedef enum logic [5:0] {
		FN_SLL = 6'd0, FN_SRL = 6'd2, FN_SRA = 6'd3,
		FN_SLLV = 6'd4, FN_SRLV = 6'd6, FN_SRAV = 6'd7,
		FN_JR = 6'd8, FN_JALR = 6'd9,
		FN_ADDU = 6'd33, FN_SUBU = 6'd35, FN_AND = 6'd36, FN_OR = 6'd37,
		FN_XOR = 6'd38, FN_NOR = 6'd39, FN_SLT = 6'd42, FN_SLTU = 6'd43
	} funct_e;

	typedef enum logic [7:0] {
		UOP_SLL = 8'd0, UOP_SRL = 8'd1, UOP_SRA = 8'd2, // shifts
		UOP_SLLV = 8'd3, UOP_SRLV = 8'd4, UOP_SRAV = 8'd5,
		UOP_JR = 8'd6, UOP_JALR = 8'd7,
		UOP_ADDU = 8'd16, UOP_SUBU = 8'd18, UOP_AND = 8'd19, UOP_OR = 8'd20,
		UOP_XOR = 8'd21, UOP_NOR = 8'd22, UOP_SLT = 8'd23, UOP_SLTU = 8'd24,
		UOP_BEQ = 8'd27, UOP_BNE = 8'd28, UOP_BLEZ = 8'd29, UOP_BGTZ = 8'd30,
		UOP_ADDIU = 8'd32, UOP_SLTI = 8'd33, UOP_SLTIU = 8'd34, UOP_ANDI = 8'd35,
		UOP_ORI = 8'd36, UOP_XORI = 8'd37, UOP_LUI = 8'd38,
		UOP_J = 8'd39, UOP_JAL = 8'd40,
		UOP_LW = 8'd45, UOP_LB = 8'd46, UOP_LBU = 8'd47, UOP_LH = 8'd48, UOP_LHU = 8'd49,
		UOP_SB = 8'd50, UOP_SH = 8'd51, UOP_SW = 8'd52,
		UOP_BLTZ = 8'd55, UOP_BGEZ = 8'd56,
		UOP_LI = 8'd153, UOP_MOVE = 8'd154, // addiu/or with rs = 0
		UOP_NOP = 8'd156,
		UOP_II = 8'd160 // illegal or unsupported instruction
	} uop_op_e;

endpackage

`default_nettype wire

// File: design/uop_if.sv
`timescale 1ns/1ps
`default_nettype none

interface uop_if
	import mips_decode_pkg::*;
#(
	parameter int ADDR_WIDTH = 64
) ();

	logic hit;
	uop_op_e op;
	reg_idx_t src_a;
	logic src_a_vld;
	reg_idx_t src_b;
	logic src_b_vld;
	reg_idx_t dst;
	logic dst_vld;
	imm_t imm;
	logic [ADDR_WIDTH-1:0] jmp_target;
	logic is_br;
	logic br_pred;
	logic is_mem;

	modport dec (
		output hit, op, src_a, src_a_vld, src_b, src_b_vld, dst, dst_vld,
		output imm, jmp_target, is_br, br_pred, is_mem
	);

	modport sel (
		input hit, op, src_a, src_a_vld, src_b, src_b_vld, dst, dst_vld,
		input imm, jmp_target, is_br, br_pred, is_mem
	);

endinterface

`default_nettype wire

// File: design/special_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module special_decoder
	import mips_decode_pkg::*;
#(
	parameter int ADDR_WIDTH = 64
) (
	input wire [31:0] insn,
	input wire [ADDR_WIDTH-1:0] insn_pred_target,
	uop_if.dec u
);

	major_op_e opcode;
	funct_e funct;
	reg_idx_t rs, rt, rd;
	logic [4:0] shamt;
	uop_op_e op;
	logic hit;
	logic shift_imm;
	logic rs_first;

	assign opcode = major_op_e'(insn[31:26]);
	assign funct = funct_e'(insn[5:0]);
	assign rs = insn[25:21];
	assign rt = insn[20:16];
	assign rd = insn[15:11];
	assign shamt = insn[10:6];

	always_comb begin
		case (funct)
			FN_SLL: op = UOP_SLL;
			FN_SRL: op = UOP_SRL;
			FN_SRA: op = UOP_SRA;
			FN_SLLV: op = UOP_SLLV;
			FN_SRLV: op = UOP_SRLV;
			FN_SRAV: op = UOP_SRAV;
			FN_ADDU: op = UOP_ADDU;
			FN_SUBU: op = UOP_SUBU;
			FN_AND: op = UOP_AND;
			FN_OR: begin
				if (rs == '0)
					op = UOP_MOVE;
				else
					op = UOP_OR;
			end
			FN_XOR: op = UOP_XOR;
			FN_NOR: op = UOP_NOR;
			FN_SLT: op = UOP_SLT;
			FN_SLTU: op = UOP_SLTU;
			default: op = UOP_II; // jr/jalr belong to branch_decoder
		endcase
		hit = (opcode == OP_SPECIAL) && (op != UOP_II);
		shift_imm = funct inside {FN_SLL, FN_SRL, FN_SRA};
		rs_first = funct == FN_SUBU; // operand order matters for subu
	end

	always_comb begin
		u.hit = hit;
		u.op = UOP_SLL; // encodes as zero
		u.src_a = '0;
		u.src_a_vld = 1'b0;
		u.src_b = '0;
		u.src_b_vld = 1'b0;
		u.dst = '0;
		u.dst_vld = 1'b0;
		u.imm = '0;
		u.jmp_target = '0;
		u.is_br = 1'b0;
		u.br_pred = 1'b0;
		u.is_mem = 1'b0;
		if (hit) begin
			u.op = (rd == '0) ? UOP_NOP : op;
			u.src_a = rs_first ? rs : rt;
			u.src_a_vld = 1'b1;
			u.src_b = (shift_imm || op == UOP_MOVE) ? '0 : (rs_first ? rt : rs);
			u.src_b_vld = !shift_imm && op != UOP_MOVE;
			u.imm = shift_imm ? imm_t'(shamt) : '0; // shamt rides in imm
			u.dst = rd;
			u.dst_vld = rd != '0;
		end
	end

endmodule

`default_nettype wire

// File: design/immediate_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module immediate_decoder
	import mips_decode_pkg::*;
(
	input wire [31:0] insn,
	uop_if.dec u
);

	major_op_e opcode;
	reg_idx_t rs, rt;
	uop_op_e op;
	logic is_alu, is_load, is_store;
	logic hit;
	logic uses_rs;

	assign opcode = major_op_e'(insn[31:26]);
	assign rs = insn[25:21];
	assign rt = insn[20:16];

	always_comb begin
		op = UOP_II;
		is_alu = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		case (opcode)
			OP_ADDIU: begin
				is_alu = 1'b1;
				if (rs == '0)
					op = UOP_LI;
				else
					op = UOP_ADDIU;
			end
			OP_SLTI: begin op = UOP_SLTI; is_alu = 1'b1; end
			OP_SLTIU: begin op = UOP_SLTIU; is_alu = 1'b1; end
			OP_ANDI: begin op = UOP_ANDI; is_alu = 1'b1; end
			OP_ORI: begin op = UOP_ORI; is_alu = 1'b1; end
			OP_XORI: begin op = UOP_XORI; is_alu = 1'b1; end
			OP_LUI: begin op = UOP_LUI; is_alu = 1'b1; end
			OP_LB: begin op = UOP_LB; is_load = 1'b1; end
			OP_LH: begin op = UOP_LH; is_load = 1'b1; end
			OP_LW: begin op = UOP_LW; is_load = 1'b1; end
			OP_LBU: begin op = UOP_LBU; is_load = 1'b1; end
			OP_LHU: begin op = UOP_LHU; is_load = 1'b1; end
			OP_SB: begin op = UOP_SB; is_store = 1'b1; end
			OP_SH: begin op = UOP_SH; is_store = 1'b1; end
			OP_SW: begin op = UOP_SW; is_store = 1'b1; end
			default: ;
		endcase
		hit = is_alu | is_load | is_store;
		uses_rs = !(op == UOP_LI || op == UOP_LUI); // li and lui read no register
	end

	always_comb begin
		u.hit = hit;
		u.op = UOP_SLL; // zero when no hit
		u.src_a = '0;
		u.src_a_vld = 1'b0;
		u.src_b = '0;
		u.src_b_vld = 1'b0;
		u.dst = '0;
		u.dst_vld = 1'b0;
		u.imm = '0;
		u.jmp_target = '0;
		u.is_br = 1'b0;
		u.br_pred = 1'b0;
		u.is_mem = 1'b0;
		if (hit) begin
			u.op = (is_alu && rt == '0) ? UOP_NOP : op;
			u.src_a = uses_rs ? rs : '0;
			u.src_a_vld = uses_rs;
			u.src_b = is_store ? rt : '0; // store data
			u.src_b_vld = is_store;
			u.dst = is_store ? '0 : rt;
			u.dst_vld = !is_store && rt != '0;
			u.imm = insn[15:0];
			u.is_mem = is_load | is_store;
		end
	end

endmodule

`default_nettype wire

// File: design/branch_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module branch_decoder
	import mips_decode_pkg::*;
#(
	parameter int ADDR_WIDTH = 64
) (
	input wire [31:0] insn,
	input wire insn_pred,
	input wire [ADDR_WIDTH-1:0] insn_pred_target,
	uop_if.dec u
);

	major_op_e opcode;
	funct_e funct;
	reg_idx_t rs, rt, rd;
	uop_op_e op;
	logic hit;

	assign opcode = major_op_e'(insn[31:26]);
	assign funct = funct_e'(insn[5:0]);
	assign rs = insn[25:21];
	assign rt = insn[20:16];
	assign rd = insn[15:11];

	always_comb begin
		op = UOP_II;
		case (opcode)
			OP_SPECIAL: begin
				if (funct == FN_JR)
					op = UOP_JR;
				else if (funct == FN_JALR)
					op = UOP_JALR;
			end
			OP_REGIMM: begin
				if (rt == 5'd0)
					op = UOP_BLTZ;
				else if (rt == 5'd1)
					op = UOP_BGEZ; // other rt values are not supported
			end
			OP_J: op = UOP_J;
			OP_JAL: op = UOP_JAL;
			OP_BEQ: op = UOP_BEQ;
			OP_BNE: op = UOP_BNE;
			OP_BLEZ: op = UOP_BLEZ;
			OP_BGTZ: op = UOP_BGTZ;
			default: ;
		endcase
		hit = op != UOP_II;
	end

	always_comb begin
		u.hit = hit;
		u.op = UOP_SLL; // zero when no hit
		u.src_a = '0;
		u.src_a_vld = 1'b0;
		u.src_b = '0;
		u.src_b_vld = 1'b0;
		u.dst = '0;
		u.dst_vld = 1'b0;
		u.imm = '0;
		u.jmp_target = '0;
		u.is_br = 1'b0;
		u.br_pred = 1'b0;
		u.is_mem = 1'b0;
		if (hit) begin
			u.op = op;
			u.is_br = 1'b1;
			case (op)
				UOP_JR, UOP_JALR: begin
					u.src_a = rs;
					u.src_a_vld = 1'b1;
					u.jmp_target = insn_pred_target; // target comes from the predictor
					if (op == UOP_JALR) begin
						u.dst = rd;
						u.dst_vld = rd != '0;
					end
				end
				UOP_J, UOP_JAL: begin
					u.jmp_target = ADDR_WIDTH'(insn[25:0]);
					if (op == UOP_JAL) begin
						u.dst = REG_RA;
						u.dst_vld = 1'b1;
						u.br_pred = 1'b1;
					end
				end
				default: begin
					u.src_a = rs;
					u.src_a_vld = 1'b1;
					u.src_b = (op == UOP_BEQ || op == UOP_BNE) ? rt : '0;
					u.src_b_vld = op == UOP_BEQ || op == UOP_BNE;
					u.imm = insn[15:0]; // branch offset
					u.br_pred = insn_pred;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/uop_stage.sv
`timescale 1ns/1ps
`default_nettype none

module uop_stage
	import mips_decode_pkg::*;
#(
	parameter int ADDR_WIDTH = 64
) (
	input wire clk,
	input wire rst,
	input wire insn_valid,
	input wire [ADDR_WIDTH-1:0] pc,
	input wire [15:0] pht_idx,
	uop_if.sel spec,
	uop_if.sel imm_dec,
	uop_if.sel br,
	output logic uop_valid,
	output uop_op_e uop_op,
	output reg_idx_t uop_src_a,
	output logic uop_src_a_vld,
	output reg_idx_t uop_src_b,
	output logic uop_src_b_vld,
	output reg_idx_t uop_dst,
	output logic uop_dst_vld,
	output imm_t uop_imm,
	output logic [ADDR_WIDTH-1:0] uop_jmp_target,
	output logic uop_is_br,
	output logic uop_br_pred,
	output logic uop_is_mem,
	output logic [ADDR_WIDTH-1:0] uop_pc,
	output logic [15:0] uop_pht_idx
);

	logic any_hit;
	logic [7:0] nxt_op;
	reg_idx_t nxt_src_a, nxt_src_b, nxt_dst;
	logic nxt_src_a_vld, nxt_src_b_vld, nxt_dst_vld;
	imm_t nxt_imm;
	logic [ADDR_WIDTH-1:0] nxt_jmp_target;
	logic nxt_is_br, nxt_br_pred, nxt_is_mem;

	assign any_hit = spec.hit | imm_dec.hit | br.hit;

	// at most one decoder hits, so an and-or mux is enough
	assign nxt_op = !any_hit ? UOP_II : (({8{spec.hit}} & spec.op)
		| ({8{imm_dec.hit}} & imm_dec.op) | ({8{br.hit}} & br.op));
	assign nxt_src_a = ({5{spec.hit}} & spec.src_a) | ({5{imm_dec.hit}} & imm_dec.src_a)
		| ({5{br.hit}} & br.src_a);
	assign nxt_src_b = ({5{spec.hit}} & spec.src_b) | ({5{imm_dec.hit}} & imm_dec.src_b)
		| ({5{br.hit}} & br.src_b);
	assign nxt_dst = ({5{spec.hit}} & spec.dst) | ({5{imm_dec.hit}} & imm_dec.dst)
		| ({5{br.hit}} & br.dst);
	assign nxt_imm = ({16{spec.hit}} & spec.imm) | ({16{imm_dec.hit}} & imm_dec.imm)
		| ({16{br.hit}} & br.imm);
	assign nxt_jmp_target = ({ADDR_WIDTH{spec.hit}} & spec.jmp_target)
		| ({ADDR_WIDTH{imm_dec.hit}} & imm_dec.jmp_target)
		| ({ADDR_WIDTH{br.hit}} & br.jmp_target);
	assign nxt_src_a_vld = (spec.hit & spec.src_a_vld) | (imm_dec.hit & imm_dec.src_a_vld)
		| (br.hit & br.src_a_vld);
	assign nxt_src_b_vld = (spec.hit & spec.src_b_vld) | (imm_dec.hit & imm_dec.src_b_vld)
		| (br.hit & br.src_b_vld);
	assign nxt_dst_vld = (spec.hit & spec.dst_vld) | (imm_dec.hit & imm_dec.dst_vld)
		| (br.hit & br.dst_vld);
	assign nxt_is_br = (spec.hit & spec.is_br) | (imm_dec.hit & imm_dec.is_br)
		| (br.hit & br.is_br);
	assign nxt_br_pred = (spec.hit & spec.br_pred) | (imm_dec.hit & imm_dec.br_pred)
		| (br.hit & br.br_pred);
	assign nxt_is_mem = (spec.hit & spec.is_mem) | (imm_dec.hit & imm_dec.is_mem)
		| (br.hit & br.is_mem);

	always_ff @(posedge clk) begin
		if (rst)
			uop_valid <= 1'b0;
		else
			uop_valid <= insn_valid;
		if (insn_valid) begin // fields hold while idle
			uop_op <= uop_op_e'(nxt_op);
			uop_src_a <= nxt_src_a;
			uop_src_a_vld <= nxt_src_a_vld;
			uop_src_b <= nxt_src_b;
			uop_src_b_vld <= nxt_src_b_vld;
			uop_dst <= nxt_dst;
			uop_dst_vld <= nxt_dst_vld;
			uop_imm <= nxt_imm;
			uop_jmp_target <= nxt_jmp_target;
			uop_is_br <= nxt_is_br;
			uop_br_pred <= nxt_br_pred;
			uop_is_mem <= nxt_is_mem;
			uop_pc <= pc;
			uop_pht_idx <= pht_idx;
		end
	end

endmodule

`default_nettype wire

// File: design/decode_mips32_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_mips32_top
	import mips_decode_pkg::*;
#(
	parameter int ADDR_WIDTH = 64
) (
	input wire clk,
	input wire rst,
	input wire insn_valid,
	input wire [31:0] insn,
	input wire [ADDR_WIDTH-1:0] pc,
	input wire insn_pred,
	input wire [15:0] pht_idx,
	input wire [ADDR_WIDTH-1:0] insn_pred_target,
	output logic uop_valid,
	output uop_op_e uop_op,
	output reg_idx_t uop_src_a,
	output logic uop_src_a_vld,
	output reg_idx_t uop_src_b,
	output logic uop_src_b_vld,
	output reg_idx_t uop_dst,
	output logic uop_dst_vld,
	output imm_t uop_imm,
	output logic [ADDR_WIDTH-1:0] uop_jmp_target,
	output logic uop_is_br,
	output logic uop_br_pred,
	output logic uop_is_mem,
	output logic [ADDR_WIDTH-1:0] uop_pc,
	output logic [15:0] uop_pht_idx
);

	uop_if #(.ADDR_WIDTH(ADDR_WIDTH)) spec_u ();
	uop_if #(.ADDR_WIDTH(ADDR_WIDTH)) imm_u ();
	uop_if #(.ADDR_WIDTH(ADDR_WIDTH)) br_u ();

	special_decoder #(.ADDR_WIDTH(ADDR_WIDTH)) u_special (
		.insn(insn),
		.insn_pred_target(insn_pred_target),
		.u(spec_u.dec)
	);

	immediate_decoder u_immediate (
		.insn(insn),
		.u(imm_u.dec)
	);

	branch_decoder #(.ADDR_WIDTH(ADDR_WIDTH)) u_branch (
		.insn(insn),
		.insn_pred(insn_pred),
		.insn_pred_target(insn_pred_target),
		.u(br_u.dec)
	);

	uop_stage #(.ADDR_WIDTH(ADDR_WIDTH)) u_stage (
		.clk(clk),
		.rst(rst),
		.insn_valid(insn_valid),
		.pc(pc),
		.pht_idx(pht_idx),
		.spec(spec_u.sel),
		.imm_dec(imm_u.sel),
		.br(br_u.sel),
		.uop_valid(uop_valid),
		.uop_op(uop_op),
		.uop_src_a(uop_src_a),
		.uop_src_a_vld(uop_src_a_vld),
		.uop_src_b(uop_src_b),
		.uop_src_b_vld(uop_src_b_vld),
		.uop_dst(uop_dst),
		.uop_dst_vld(uop_dst_vld),
		.uop_imm(uop_imm),
		.uop_jmp_target(uop_jmp_target),
		.uop_is_br(uop_is_br),
		.uop_br_pred(uop_br_pred),
		.uop_is_mem(uop_is_mem),
		.uop_pc(uop_pc),
		.uop_pht_idx(uop_pht_idx)
	);

endmodule

`default_nettype wire

// File: sim/decode_model_pkg.sv
`default_nettype none

package decode_model_pkg;

	import mips_decode_pkg::*;

	typedef struct packed {
		uop_op_e op;
		reg_idx_t src_a;
		logic src_a_vld;
		reg_idx_t src_b;
		logic src_b_vld;
		reg_idx_t dst;
		logic dst_vld;
		imm_t imm;
		logic [63:0] jmp_target;
		logic is_br;
		logic br_pred;
		logic is_mem;
	} exp_uop_t;

	// register-register micro-op for a SPECIAL funct, II when not kept
	function automatic uop_op_e special_op(input logic [5:0] fn);
		case (fn)
			FN_SLL: return UOP_SLL;
			FN_SRL: return UOP_SRL;
			FN_SRA: return UOP_SRA;
			FN_SLLV: return UOP_SLLV;
			FN_SRLV: return UOP_SRLV;
			FN_SRAV: return UOP_SRAV;
			FN_ADDU: return UOP_ADDU;
			FN_SUBU: return UOP_SUBU;
			FN_AND: return UOP_AND;
			FN_OR: return UOP_OR;
			FN_XOR: return UOP_XOR;
			FN_NOR: return UOP_NOR;
			FN_SLT: return UOP_SLT;
			FN_SLTU: return UOP_SLTU;
			default: return UOP_II;
		endcase
	endfunction

	function automatic uop_op_e imm_op(input logic [5:0] opc);
		case (opc)
			OP_ADDIU: return UOP_ADDIU;
			OP_SLTI: return UOP_SLTI;
			OP_SLTIU: return UOP_SLTIU;
			OP_ANDI: return UOP_ANDI;
			OP_ORI: return UOP_ORI;
			OP_XORI: return UOP_XORI;
			OP_LUI: return UOP_LUI;
			OP_LB: return UOP_LB;
			OP_LH: return UOP_LH;
			OP_LW: return UOP_LW;
			OP_LBU: return UOP_LBU;
			OP_LHU: return UOP_LHU;
			OP_SB: return UOP_SB;
			OP_SH: return UOP_SH;
			OP_SW: return UOP_SW;
			default: return UOP_II;
		endcase
	endfunction

	function automatic exp_uop_t expect_uop(input logic [31:0] insn, input logic pred,
			input logic [63:0] pred_target);
		exp_uop_t e;
		logic [5:0] opc;
		logic [5:0] fn;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		logic reads_rs;
		e = '0;
		e.op = UOP_II;
		opc = insn[31:26];
		fn = insn[5:0];
		rs = insn[25:21];
		rt = insn[20:16];
		rd = insn[15:11];
		if (opc == OP_SPECIAL && (fn == FN_JR || fn == FN_JALR)) begin
			e.op = (fn == FN_JR) ? UOP_JR : UOP_JALR;
			e.is_br = 1'b1;
			e.src_a = rs;
			e.src_a_vld = 1'b1;
			e.jmp_target = pred_target; // register jumps use the predicted target
			if (fn == FN_JALR) begin
				e.dst = rd;
				e.dst_vld = (rd != 5'd0);
			end
		end else if (opc == OP_SPECIAL && special_op(fn) != UOP_II) begin
			e.op = special_op(fn);
			if (fn == FN_OR && rs == 5'd0)
				e.op = UOP_MOVE;
			e.src_a = (fn == FN_SUBU) ? rs : rt;
			e.src_a_vld = 1'b1;
			if (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA) begin
				e.imm = {11'd0, insn[10:6]}; // shamt
			end else if (e.op != UOP_MOVE) begin
				e.src_b = (fn == FN_SUBU) ? rt : rs;
				e.src_b_vld = 1'b1;
			end
			e.dst = rd;
			e.dst_vld = (rd != 5'd0);
			if (rd == 5'd0)
				e.op = UOP_NOP;
		end else if (imm_op(opc) != UOP_II) begin
			e.op = imm_op(opc);
			if (e.op == UOP_ADDIU && rs == 5'd0)
				e.op = UOP_LI;
			reads_rs = !(e.op == UOP_LI || e.op == UOP_LUI);
			e.src_a = reads_rs ? rs : 5'd0;
			e.src_a_vld = reads_rs;
			e.imm = insn[15:0];
			e.is_mem = (opc >= 6'd32);
			if (opc >= 6'd40) begin // stores
				e.src_b = rt;
				e.src_b_vld = 1'b1;
			end else begin
				e.dst = rt;
				e.dst_vld = (rt != 5'd0);
				if (opc < 6'd32 && rt == 5'd0)
					e.op = UOP_NOP;
			end
		end else begin
			case (opc)
				OP_REGIMM: begin
					if (rt == 5'd0)
						e.op = UOP_BLTZ;
					else if (rt == 5'd1)
						e.op = UOP_BGEZ;
				end
				OP_BEQ: e.op = UOP_BEQ;
				OP_BNE: e.op = UOP_BNE;
				OP_BLEZ: e.op = UOP_BLEZ;
				OP_BGTZ: e.op = UOP_BGTZ;
				OP_J: e.op = UOP_J;
				OP_JAL: e.op = UOP_JAL;
				default: ;
			endcase
			if (e.op == UOP_J || e.op == UOP_JAL) begin
				e.is_br = 1'b1;
				e.jmp_target = {38'd0, insn[25:0]};
				if (e.op == UOP_JAL) begin
					e.dst = REG_RA;
					e.dst_vld = 1'b1;
					e.br_pred = 1'b1;
				end
			end else if (e.op != UOP_II) begin
				e.is_br = 1'b1;
				e.br_pred = pred;
				e.imm = insn[15:0]; // branch offset
				e.src_a = rs;
				e.src_a_vld = 1'b1;
				if (e.op == UOP_BEQ || e.op == UOP_BNE) begin
					e.src_b = rt;
					e.src_b_vld = 1'b1;
				end
			end
		end
		return e;
	endfunction

endpackage

`default_nettype wire

// File: sim/decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_tb
	import mips_decode_pkg::*;
	import decode_model_pkg::*;
();

	// stimulus slots per test, drain cycles included
	localparam int TOTAL_SLOTS = 2 + 8 + (14 * 4 + 2) + (26 + 2) + (15 * 3 + 2 + 2)
		+ (10 * 4 + 2) + (3 * 4 + 2);

	logic clk;
	logic rst;
	logic insn_valid;
	logic [31:0] insn;
	logic [63:0] pc;
	logic insn_pred;
	logic [15:0] pht_idx;
	logic [63:0] insn_pred_target;
	logic uop_valid;
	uop_op_e uop_op;
	reg_idx_t uop_src_a;
	logic uop_src_a_vld;
	reg_idx_t uop_src_b;
	logic uop_src_b_vld;
	reg_idx_t uop_dst;
	logic uop_dst_vld;
	imm_t uop_imm;
	logic [63:0] uop_jmp_target;
	logic uop_is_br;
	logic uop_br_pred;
	logic uop_is_mem;
	logic [63:0] uop_pc;
	logic [15:0] uop_pht_idx;

	exp_uop_t exp_u;
	logic exp_valid;
	logic [63:0] exp_pc;
	logic [15:0] exp_pht_idx;

	integer seed = 32'h28742c81;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	logic [5:0] alu_functs [14] = '{6'd0, 6'd2, 6'd3, 6'd4, 6'd6, 6'd7, 6'd33, 6'd35,
		6'd36, 6'd37, 6'd38, 6'd39, 6'd42, 6'd43};
	logic [5:0] imm_alu_ops [7] = '{6'd9, 6'd10, 6'd11, 6'd12, 6'd13, 6'd14, 6'd15};
	logic [5:0] load_ops [5] = '{6'd32, 6'd33, 6'd35, 6'd36, 6'd37};
	logic [5:0] store_ops [3] = '{6'd40, 6'd41, 6'd43};

	decode_mips32_top #(.ADDR_WIDTH(64)) DUT (
		.clk(clk),
		.rst(rst),
		.insn_valid(insn_valid),
		.insn(insn),
		.pc(pc),
		.insn_pred(insn_pred),
		.pht_idx(pht_idx),
		.insn_pred_target(insn_pred_target),
		.uop_valid(uop_valid),
		.uop_op(uop_op),
		.uop_src_a(uop_src_a),
		.uop_src_a_vld(uop_src_a_vld),
		.uop_src_b(uop_src_b),
		.uop_src_b_vld(uop_src_b_vld),
		.uop_dst(uop_dst),
		.uop_dst_vld(uop_dst_vld),
		.uop_imm(uop_imm),
		.uop_jmp_target(uop_jmp_target),
		.uop_is_br(uop_is_br),
		.uop_br_pred(uop_br_pred),
		.uop_is_mem(uop_is_mem),
		.uop_pc(uop_pc),
		.uop_pht_idx(uop_pht_idx)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// expected uop, one cycle behind the accepted instruction
	always @(posedge clk) begin
		if (rst)
			exp_valid <= 1'b0;
		else
			exp_valid <= insn_valid;
		if (insn_valid) begin
			exp_u <= expect_uop(insn, insn_pred, insn_pred_target);
			exp_pc <= pc;
			exp_pht_idx <= pht_idx;
		end
	end

	task automatic report_mismatch(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("mismatch %s: expected %h, got %h", name, expected, actual);
		errors++;
	endtask

	a_valid: assert property (@(posedge clk) disable iff (rst) uop_valid == exp_valid)
		else report_mismatch("uop_valid", $sampled(exp_valid), $sampled(uop_valid));
	a_op: assert property (@(posedge clk) disable iff (rst) uop_valid |-> uop_op == exp_u.op)
		else report_mismatch("uop_op", $sampled(exp_u.op), $sampled(uop_op));
	a_src_a: assert property (@(posedge clk) disable iff (rst)
		uop_valid |-> uop_src_a == exp_u.src_a)
		else report_mismatch("uop_src_a", $sampled(exp_u.src_a), $sampled(uop_src_a));
	a_src_a_vld: assert property (@(posedge clk) disable iff (rst)
		uop_valid |-> uop_src_a_vld == exp_u.src_a_vld)
		else report_mismatch("uop_src_a_vld", $sampled(exp_u.src_a_vld), $sampled(uop_src_a_vld));
	a_src_b: assert property (@(posedge clk) disable iff (rst)
		uop_valid |-> uop_src_b == exp_u.src_b)
		else report_mismatch("uop_src_b", $sampled(exp_u.src_b), $sampled(uop_src_b));
	a_src_b_vld: assert property (@(posedge clk) disable iff (rst)
		uop_valid |-> uop_src_b_vld == exp_u.src_b_vld)
		else report_mismatch("uop_src_b_vld", $sampled(exp_u.src_b_vld), $sampled(uop_src_b_vld));
	a_dst: assert property (@(posedge clk) disable iff (rst) uop_valid |-> uop_dst == exp_u.dst)
		else report_mismatch("uop_dst", $sampled(exp_u.dst), $sampled(uop_dst));
	a_dst_vld: assert property (@(posedge clk) disable iff (rst)
		uop_valid |-> uop_dst_vld == exp_u.dst_vld)
		else report_mismatch("uop_dst_vld", $sampled(exp_u.dst_vld), $sampled(uop_dst_vld));
	a_imm: assert property (@(posedge clk) disable iff (rst) uop_valid |-> uop_imm == exp_u.imm)
		else report_mismatch("uop_imm", $sampled(exp_u.imm), $sampled(uop_imm));
	a_jmp_target: assert property (@(posedge clk) disable iff (rst)
		uop_valid |-> uop_jmp_target == exp_u.jmp_target)
		else report_mismatch("uop_jmp_target", $sampled(exp_u.jmp_target),
			$sampled(uop_jmp_target));
	a_is_br: assert property (@(posedge clk) disable iff (rst)
		uop_valid |-> uop_is_br == exp_u.is_br)
		else report_mismatch("uop_is_br", $sampled(exp_u.is_br), $sampled(uop_is_br));
	a_br_pred: assert property (@(posedge clk) disable iff (rst)
		uop_valid |-> uop_br_pred == exp_u.br_pred)
		else report_mismatch("uop_br_pred", $sampled(exp_u.br_pred), $sampled(uop_br_pred));
	a_is_mem: assert property (@(posedge clk) disable iff (rst)
		uop_valid |-> uop_is_mem == exp_u.is_mem)
		else report_mismatch("uop_is_mem", $sampled(exp_u.is_mem), $sampled(uop_is_mem));
	a_pc: assert property (@(posedge clk) disable iff (rst) uop_valid |-> uop_pc == exp_pc)
		else report_mismatch("uop_pc", $sampled(exp_pc), $sampled(uop_pc));
	a_pht_idx: assert property (@(posedge clk) disable iff (rst)
		uop_valid |-> uop_pht_idx == exp_pht_idx)
		else report_mismatch("uop_pht_idx", $sampled(exp_pht_idx), $sampled(uop_pht_idx));

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	function automatic logic [31:0] r_format(input logic [5:0] fn, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {6'd0, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] i_format(input logic [5:0] opc, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic logic [31:0] j_format(input logic [5:0] opc, input logic [25:0] target);
		return {opc, target};
	endfunction

	// one accepted instruction with random side inputs
	task automatic issue(input logic [31:0] word);
		logic [31:0] r;
		r = next_random();
		insn_valid = 1'b1;
		insn = word;
		pc = {next_random(), next_random()};
		pht_idx = r[15:0];
		insn_pred = r[16];
		insn_pred_target = {next_random(), next_random()};
		@(posedge clk);
		#2;
	endtask

	task automatic idle_cycle();
		insn_valid = 1'b0;
		insn = next_random(); // junk, must be ignored
		@(posedge clk);
		#2;
	endtask

	task automatic close_test(input string name, input int start);
		int n;
		idle_cycle();
		idle_cycle(); // last uop checked by now
		n = errors - start;
		if (n == 0)
			tests_passed++;
		else
			tests_failed++;
		$display("test %s: %s, %0d errors", name, (n == 0) ? "ok" : "failed", n);
	endtask

	task automatic test_reset_latency();
		int start;
		logic [31:0] r;
		start = errors;
		assert (uop_valid === 1'b0) else begin
			$display("uop_valid is not low after reset");
			errors++;
		end
		r = next_random();
		issue(r_format(FN_ADDU, r[25:21], r[20:16], r[15:11], 5'd0));
		idle_cycle();
		issue(r_format(FN_XOR, r[20:16], r[15:11], r[25:21], 5'd0));
		issue(r_format(FN_SUBU, r[15:11], r[25:21], r[20:16], 5'd0)); // back to back
		idle_cycle();
		idle_cycle();
		close_test("reset_latency", start);
	endtask

	task automatic test_special();
		int start;
		logic [31:0] r;
		start = errors;
		foreach (alu_functs[i]) begin
			for (int k = 0; k < 4; k++) begin
				r = next_random();
				issue(r_format(alu_functs[i], (k == 0) ? 5'd0 : r[25:21], r[20:16],
					r[15:11], r[10:6]));
			end
		end
		close_test("special_alu", start);
	endtask

	task automatic test_zero_dst();
		int start;
		logic [31:0] r;
		start = errors;
		foreach (alu_functs[i]) begin
			r = next_random();
			issue(r_format(alu_functs[i], r[25:21], r[20:16], 5'd0, r[10:6]));
		end
		foreach (imm_alu_ops[i]) begin
			r = next_random();
			issue(i_format(imm_alu_ops[i], r[25:21], 5'd0, r[15:0]));
		end
		foreach (load_ops[i]) begin
			r = next_random();
			issue(i_format(load_ops[i], r[25:21], 5'd0, r[15:0]));
		end
		close_test("zero_dst", start);
	endtask

	task automatic test_imm_mem();
		int start;
		logic [31:0] r;
		start = errors;
		for (int k = 0; k < 3; k++) begin
			foreach (imm_alu_ops[i]) begin
				r = next_random();
				issue(i_format(imm_alu_ops[i], r[25:21], r[20:16], r[15:0]));
			end
			foreach (load_ops[i]) begin
				r = next_random();
				issue(i_format(load_ops[i], r[25:21], r[20:16], r[15:0]));
			end
			foreach (store_ops[i]) begin
				r = next_random();
				issue(i_format(store_ops[i], r[25:21], r[20:16], r[15:0]));
			end
		end
		r = next_random();
		issue(i_format(OP_ADDIU, 5'd0, r[20:16], r[15:0])); // li
		issue(i_format(OP_ADDIU, 5'd0, r[25:21], r[31:16]));
		close_test("imm_mem", start);
	endtask

	task automatic test_branches();
		int start;
		logic [31:0] r;
		start = errors;
		for (int k = 0; k < 4; k++) begin
			r = next_random();
			issue(r_format(FN_JR, r[25:21], 5'd0, 5'd0, 5'd0));
			issue(r_format(FN_JALR, r[25:21], 5'd0, r[15:11], 5'd0));
			issue(i_format(OP_REGIMM, r[25:21], 5'd0, r[15:0]));
			issue(i_format(OP_REGIMM, r[25:21], 5'd1, r[15:0]));
			issue(i_format(OP_BEQ, r[25:21], r[20:16], r[15:0]));
			issue(i_format(OP_BNE, r[20:16], r[25:21], r[15:0]));
			issue(i_format(OP_BLEZ, r[25:21], 5'd0, r[15:0]));
			issue(i_format(OP_BGTZ, r[25:21], 5'd0, r[15:0]));
			issue(j_format(OP_J, r[25:0]));
			issue(j_format(OP_JAL, r[31:6]));
		end
		close_test("branches", start);
	endtask

	task automatic test_dropped();
		int start;
		logic [31:0] r;
		start = errors;
		for (int k = 0; k < 4; k++) begin
			r = next_random();
			issue(j_format(6'd17, r[25:0])); // cop1
			issue(j_format(6'd28, r[25:0])); // special2
			issue(r_format(6'd24, r[25:21], r[20:16], 5'd0, 5'd0)); // mult
		end
		close_test("dropped", start);
	endtask

	initial begin
		#((TOTAL_SLOTS + 20) * 40);
		$display("timeout: the tests did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		rst = 1'b1;
		insn_valid = 1'b0;
		insn = '0;
		pc = '0;
		insn_pred = 1'b0;
		pht_idx = '0;
		insn_pred_target = '0;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		test_reset_latency();
		test_special();
		test_zero_dst();
		test_imm_mem();
		test_branches();
		test_dropped();
		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
design/mips_decode_pkg.sv
design/uop_if.sv
design/special_decoder.sv
design/immediate_decoder.sv
design/branch_decoder.sv
design/uop_stage.sv
design/decode_mips32_top.sv
sim/decode_model_pkg.sv
sim/decode_tb.sv

// File: Bender.yml
package:
  name: decode_mips32

sources:
  - design/mips_decode_pkg.sv
  - design/uop_if.sv
  - design/special_decoder.sv
  - design/immediate_decoder.sv
  - design/branch_decoder.sv
  - design/uop_stage.sv
  - design/decode_mips32_top.sv
  - target: simulation
    files:
      - sim/decode_model_pkg.sv
      - sim/decode_tb.sv
